/* rtl/lsu_macros.svh */
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// width of a register value and of a bus data word
`define LSU_XLEN 32

// width of a byte address
`define LSU_ADDR_W 32

// one strobe bit per byte lane
`define LSU_STRB_W (`LSU_XLEN / 8)

`endif

/* rtl/lsu_pkg.sv */
`default_nettype none

`include "lsu_macros.svh"

package lsu_pkg;

	typedef logic [`LSU_XLEN-1:0]   xlen_t;
	typedef logic [`LSU_ADDR_W-1:0] addr_t;
	typedef logic [`LSU_STRB_W-1:0] strb_t;
	typedef logic [4:0]             reg_idx_t;

	typedef enum logic [1:0] {
		NONE  = 2'd0,
		LOAD  = 2'd1,
		STORE = 2'd2
	} lsu_op_e;

	// same encoding as the funct3 field of the load opcodes
	typedef enum logic [2:0] {
		BYTE   = 3'd0,
		HALF   = 3'd1,
		WORD   = 3'd2,
		BYTE_U = 3'd4,
		HALF_U = 3'd5
	} lsu_size_e;

	typedef enum logic [1:0] {
		IDLE    = 2'd0,
		BUS_REQ = 2'd1,
		BUS_RSP = 2'd2,
		DONE    = 2'd3
	} lsu_state_e;

	// one memory instruction from execute, addr holds the ALU result
	typedef struct packed {
		lsu_op_e   op;
		lsu_size_e size;
		addr_t     addr;
		xlen_t     wdata;
		reg_idx_t  rd;
	} lsu_req_t;

	typedef struct packed {
		reg_idx_t rd;
		xlen_t    data;
		logic     err;
	} lsu_rsp_t;

	typedef struct packed {
		addr_t addr;
		logic  we;
		xlen_t wdata;
		strb_t wstrb;
	} mem_req_t;

	typedef struct packed {
		xlen_t rdata;
		logic  err;
	} mem_rsp_t;

endpackage

`default_nettype wire

/* rtl/lsu_ctrl.sv */
`default_nettype none

module lsu_ctrl (
	input  logic             clk,
	input  logic             rstn,
	input  logic             req_valid_i,
	input  lsu_pkg::lsu_op_e op_i,
	input  logic             misalign_i,
	input  logic             mem_req_ready_i,
	input  logic             mem_rsp_valid_i,
	output logic             req_ready_o,
	output logic             accept_o,
	output logic             mem_req_valid_o,
	output logic             mem_rsp_ready_o,
	output logic             rsp_capture_o,
	output logic             rsp_valid_o
);

	import lsu_pkg::*;

	lsu_state_e state_q;
	lsu_state_e state_d;

	// bus access needed
	logic need_bus;

	logic req_hs;
	logic rsp_hs;

	// NONE and misaligned accesses never reach the bus
	assign need_bus = (op_i != NONE) && !misalign_i;

	assign req_ready_o = (state_q == IDLE);
	assign accept_o    = req_ready_o && req_valid_i;

	// valid held for the whole state, so it only drops after ready
	assign mem_req_valid_o = (state_q == BUS_REQ);
	assign mem_rsp_ready_o = (state_q == BUS_RSP);

	assign req_hs = mem_req_valid_o && mem_req_ready_i;
	assign rsp_hs = mem_rsp_ready_o && mem_rsp_valid_i;

	// result register load, direct path or bus response
	assign rsp_capture_o = (accept_o && !need_bus) || rsp_hs;

	// single write-back pulse
	assign rsp_valid_o = (state_q == DONE);

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (accept_o) begin
					if (need_bus) begin
						state_d = BUS_REQ;
					end else begin
						state_d = DONE;
					end
				end
			end
			BUS_REQ: begin
				// stretched by slave back-pressure
				if (req_hs) begin
					state_d = BUS_RSP;
				end
			end
			BUS_RSP: begin
				if (rsp_hs) begin
					state_d = DONE;
				end
			end
			DONE: begin
				state_d = IDLE;
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rstn) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

endmodule

`default_nettype wire

/* rtl/lsu_store_align.sv */
`default_nettype none

module lsu_store_align (
	input  lsu_pkg::lsu_req_t req_i,
	output lsu_pkg::mem_req_t mem_req_o,
	output logic              misalign_o
);

	import lsu_pkg::*;

	logic [1:0] offset;
	strb_t      base_strb;
	xlen_t      lane_data;

	assign offset = req_i.addr[1:0];

	// replicate narrow data so every lane carries it
	always_comb begin
		case (req_i.size)
			BYTE, BYTE_U: begin
				base_strb  = 4'b0001;
				lane_data  = {4{req_i.wdata[7:0]}};
				misalign_o = 1'b0;
			end
			HALF, HALF_U: begin
				base_strb  = 4'b0011;
				lane_data  = {2{req_i.wdata[15:0]}};
				misalign_o = (req_i.op != NONE) && offset[0];
			end
			default: begin
				base_strb  = 4'b1111;
				lane_data  = req_i.wdata;
				misalign_o = (req_i.op != NONE) && (offset != 2'b00);
			end
		endcase
	end

	// word-aligned address
	assign mem_req_o.addr  = req_i.addr & ~addr_t'(3);
	assign mem_req_o.we    = (req_i.op == STORE);
	assign mem_req_o.wdata = lane_data;
	// loads write nothing
	assign mem_req_o.wstrb = (req_i.op == STORE) ? strb_t'(base_strb << offset) : '0;

endmodule

`default_nettype wire

/* rtl/lsu_load_extend.sv */
`default_nettype none

module lsu_load_extend (
	input  lsu_pkg::lsu_req_t req_i,
	input  lsu_pkg::mem_rsp_t mem_rsp_i,
	input  logic              misalign_i,
	output lsu_pkg::lsu_rsp_t rsp_o
);

	import lsu_pkg::*;

	logic [1:0] offset;
	xlen_t      shifted;
	xlen_t      ext_data;
	logic       bus_err;
	logic       err;

	assign offset = req_i.addr[1:0];

	// addressed byte moved down to lane 0
	assign shifted = mem_rsp_i.rdata >> {offset, 3'b000};

	always_comb begin
		case (req_i.size)
			BYTE:    ext_data = {{24{shifted[7]}}, shifted[7:0]};
			HALF:    ext_data = {{16{shifted[15]}}, shifted[15:0]};
			BYTE_U:  ext_data = {24'd0, shifted[7:0]};
			HALF_U:  ext_data = {16'd0, shifted[15:0]};
			default: ext_data = shifted;
		endcase
	end

	// bus error only counts when the bus was used
	assign bus_err = (req_i.op != NONE) && mem_rsp_i.err;
	assign err     = misalign_i || bus_err;

	always_comb begin
		if (err) begin
			rsp_o.data = '0;
		end else begin
			case (req_i.op)
				LOAD:    rsp_o.data = ext_data;
				STORE:   rsp_o.data = '0;
				// non-memory instruction writes back the ALU result
				default: rsp_o.data = xlen_t'(req_i.addr);
			endcase
		end
	end

	assign rsp_o.rd  = req_i.rd;
	assign rsp_o.err = err;

endmodule

`default_nettype wire

/* rtl/lsu_top.sv */
`default_nettype none

module lsu_top (
	input  logic              clk,
	input  logic              rstn,
	input  logic              req_valid_i,
	input  lsu_pkg::lsu_req_t req_i,
	output logic              req_ready_o,
	output logic              rsp_valid_o,
	output lsu_pkg::lsu_rsp_t rsp_o,
	output logic              mem_req_valid_o,
	output lsu_pkg::mem_req_t mem_req_o,
	input  logic              mem_req_ready_i,
	input  logic              mem_rsp_valid_i,
	input  lsu_pkg::mem_rsp_t mem_rsp_i,
	output logic              mem_rsp_ready_o
);

	import lsu_pkg::*;

	lsu_req_t req_q;
	lsu_req_t req_view;
	lsu_rsp_t rsp_d;
	lsu_rsp_t rsp_q;

	logic accept;
	logic rsp_capture;
	logic misalign;

	// in IDLE the datapath looks at the incoming request so that
	// the direct path can decide and capture in the accept cycle
	assign req_view = req_ready_o ? req_i : req_q;

	lsu_ctrl lsu_ctrl_inst (
		.clk             (clk),
		.rstn            (rstn),
		.req_valid_i     (req_valid_i),
		.op_i            (req_view.op),
		.misalign_i      (misalign),
		.mem_req_ready_i (mem_req_ready_i),
		.mem_rsp_valid_i (mem_rsp_valid_i),
		.req_ready_o     (req_ready_o),
		.accept_o        (accept),
		.mem_req_valid_o (mem_req_valid_o),
		.mem_rsp_ready_o (mem_rsp_ready_o),
		.rsp_capture_o   (rsp_capture),
		.rsp_valid_o     (rsp_valid_o)
	);

	lsu_store_align lsu_store_align_inst (
		.req_i      (req_view),
		.mem_req_o  (mem_req_o),
		.misalign_o (misalign)
	);

	lsu_load_extend lsu_load_extend_inst (
		.req_i      (req_view),
		.mem_rsp_i  (mem_rsp_i),
		.misalign_i (misalign),
		.rsp_o      (rsp_d)
	);

	// request held for the whole access
	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= req_i;
		end
	end

	// write-back value, presented while rsp_valid_o is high
	always_ff @(posedge clk) begin
		if (rsp_capture) begin
			rsp_q <= rsp_d;
		end
	end

	assign rsp_o = rsp_q;

endmodule

`default_nettype wire

/* tb/lsu_mem_model.sv */
`default_nettype none

module lsu_mem_model (
	input  logic              clk,
	input  logic              rstn,
	input  logic              stall_en_i,
	input  logic              mem_req_valid_i,
	input  lsu_pkg::mem_req_t mem_req_i,
	output logic              mem_req_ready_o,
	output logic              mem_rsp_valid_o,
	output lsu_pkg::mem_rsp_t mem_rsp_o,
	input  logic              mem_rsp_ready_i
);

	import lsu_pkg::*;

	// accesses in this byte range answer with a bus error
	localparam addr_t ERR_LO = 32'h0000_03c0;
	localparam addr_t ERR_HI = 32'h0000_0400;

	logic [31:0] mem [0:255];
	logic        pending;
	logic [7:0]  idx;
	logic        in_window;

	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = (addr_t'(i * 4) * 32'h0100_0193) ^ 32'hc3a5_5a3c;
		end
	end

	assign idx       = mem_req_i.addr[9:2];
	assign in_window = (mem_req_i.addr >= ERR_LO) && (mem_req_i.addr < ERR_HI);

	always @(posedge clk) begin
		if (rstn) begin
			mem_req_ready_o <= 1'b0;
			mem_rsp_valid_o <= 1'b0;
			mem_rsp_o       <= '0;
			pending         <= 1'b0;
		end else begin
			mem_req_ready_o <= !stall_en_i || ($urandom % 4 != 0);
			if (mem_req_valid_i && mem_req_ready_o) begin
				if (in_window) begin
					mem_rsp_o <= '{rdata: '0, err: 1'b1};
				end else begin
					for (int b = 0; b < 4; b++) begin
						if (mem_req_i.we && mem_req_i.wstrb[b]) begin
							mem[idx][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
						end
					end
					mem_rsp_o <= '{rdata: mem[idx], err: 1'b0};
				end
				pending <= 1'b1;
			end
			// response delayed by a random number of cycles when stalling
			if (mem_rsp_valid_o && mem_rsp_ready_i) begin
				mem_rsp_valid_o <= 1'b0;
			end else if (pending && !mem_rsp_valid_o && (!stall_en_i || $urandom % 3 == 0)) begin
				mem_rsp_valid_o <= 1'b1;
				pending         <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* tb/lsu_properties.sv */
`default_nettype none

module lsu_properties (
	input logic              clk,
	input logic              rstn,
	input logic              req_ready_i,
	input logic              mem_req_valid_i,
	input logic              mem_req_ready_i,
	input lsu_pkg::mem_req_t mem_req_i,
	input logic              mem_rsp_ready_i,
	input logic              rsp_valid_i
);

	// number of assertion failures so far
	int unsigned fail_cnt = 0;

	// valid may only drop after the slave took the request
	a_req_hold: assert property (@(posedge clk) disable iff (rstn)
		mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i)
		else begin
			$error("mem_req_valid_o dropped before mem_req_ready_i");
			fail_cnt++;
		end

	a_req_stable: assert property (@(posedge clk) disable iff (rstn)
		mem_req_valid_i && !mem_req_ready_i |=> $stable(mem_req_i))
		else begin
			$error("mem_req_o changed while waiting for ready");
			fail_cnt++;
		end

	a_rsp_pulse: assert property (@(posedge clk) disable iff (rstn)
		rsp_valid_i |=> !rsp_valid_i)
		else begin
			$error("rsp_valid_o longer than one cycle");
			fail_cnt++;
		end

	// any busy state means not IDLE
	a_ready_idle: assert property (@(posedge clk) disable iff (rstn)
		(mem_req_valid_i || mem_rsp_ready_i || rsp_valid_i) |-> !req_ready_i)
		else begin
			$error("req_ready_o high outside IDLE");
			fail_cnt++;
		end

endmodule

`default_nettype wire

/* tb/lsu_tb.sv */
`default_nettype none

module lsu_tb;

	import lsu_pkg::*;

	localparam int    TIMEOUT = 200;
	localparam addr_t ERR_LO  = 32'h0000_03c0;
	localparam addr_t ERR_HI  = 32'h0000_0400;

	logic     clk;
	logic     rstn;
	logic     req_valid;
	lsu_req_t req;
	logic     req_ready;
	logic     rsp_valid;
	lsu_rsp_t rsp;
	logic     mem_req_valid;
	mem_req_t mem_req;
	logic     mem_req_ready;
	logic     mem_rsp_valid;
	mem_rsp_t mem_rsp;
	logic     mem_rsp_ready;
	logic     stall_en;

	logic [7:0] shadow [0:1023];
	lsu_rsp_t   exp_q[$];
	int         cyc_q[$];
	int         cyc;
	int         mem_req_cnt;
	int         err_cnt;
	int         check_cnt;
	int         test_cnt;
	int         test_base;
	int         wait_cnt;

	lsu_top lsu_top_inst (
		.clk(clk), .rstn(rstn),
		.req_valid_i(req_valid), .req_i(req), .req_ready_o(req_ready),
		.rsp_valid_o(rsp_valid), .rsp_o(rsp),
		.mem_req_valid_o(mem_req_valid), .mem_req_o(mem_req), .mem_req_ready_i(mem_req_ready),
		.mem_rsp_valid_i(mem_rsp_valid), .mem_rsp_i(mem_rsp), .mem_rsp_ready_o(mem_rsp_ready)
	);

	lsu_mem_model lsu_mem_model_inst (
		.clk(clk), .rstn(rstn), .stall_en_i(stall_en),
		.mem_req_valid_i(mem_req_valid), .mem_req_i(mem_req), .mem_req_ready_o(mem_req_ready),
		.mem_rsp_valid_o(mem_rsp_valid), .mem_rsp_o(mem_rsp), .mem_rsp_ready_i(mem_rsp_ready)
	);

	bind lsu_top lsu_properties lsu_properties_inst (
		.clk(clk), .rstn(rstn), .req_ready_i(req_ready_o),
		.mem_req_valid_i(mem_req_valid_o), .mem_req_ready_i(mem_req_ready_i),
		.mem_req_i(mem_req_o), .mem_rsp_ready_i(mem_rsp_ready_o), .rsp_valid_i(rsp_valid_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (mem_req_valid && mem_req_ready) begin
			mem_req_cnt <= mem_req_cnt + 1;
		end
	end

	function automatic xlen_t fill_word(addr_t a);
		return (a * 32'h0100_0193) ^ 32'hc3a5_5a3c;
	endfunction

	function automatic logic misaligned(lsu_req_t r);
		if (r.op == NONE) begin
			return 1'b0;
		end
		if (r.size == HALF || r.size == HALF_U) begin
			return r.addr[0];
		end
		return (r.size == WORD) && (r.addr[1:0] != 2'b00);
	endfunction

	// expected write-back from the response rules and the shadow bytes
	function automatic lsu_rsp_t expect_rsp(lsu_req_t r);
		lsu_rsp_t e;
		int       a;
		a      = int'(r.addr[9:0]);
		e.rd   = r.rd;
		e.err  = 1'b0;
		e.data = '0;
		if (r.op == NONE) begin
			e.data = r.addr;
		end else if (misaligned(r) || (r.addr >= ERR_LO && r.addr < ERR_HI)) begin
			e.err = 1'b1;
		end else if (r.op == LOAD) begin
			case (r.size)
				BYTE:    e.data = {{24{shadow[a][7]}}, shadow[a]};
				BYTE_U:  e.data = {24'd0, shadow[a]};
				HALF:    e.data = {{16{shadow[a+1][7]}}, shadow[a+1], shadow[a]};
				HALF_U:  e.data = {16'd0, shadow[a+1], shadow[a]};
				default: e.data = {shadow[a+3], shadow[a+2], shadow[a+1], shadow[a]};
			endcase
		end
		return e;
	endfunction

	task automatic update_shadow(lsu_req_t r);
		lsu_rsp_t e;
		int       a;
		int       n;
		a = int'(r.addr[9:0]);
		n = (r.size == WORD) ? 4 : ((r.size == HALF || r.size == HALF_U) ? 2 : 1);
		e = expect_rsp(r);
		if (r.op == STORE && !e.err) begin
			for (int k = 0; k < n; k++) begin
				shadow[a+k] = r.wdata[8*k +: 8];
			end
		end
	endtask

	task automatic check_value(string name, xlen_t got, xlen_t exp);
		check_cnt++;
		if (got !== exp) begin
			$display("[ERROR] %0t %s got 0x%h expected 0x%h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic abort_run(string why);
		err_cnt++;
		$display("%s", why);
		$display("Test FAILED");
		$finish;
	endtask

	// drives at a falling edge and returns at one
	task automatic issue(lsu_op_e op, lsu_size_e size, addr_t addr, xlen_t wdata, reg_idx_t rd);
		lsu_req_t r;
		int       waited;
		r         = '{op: op, size: size, addr: addr, wdata: wdata, rd: rd};
		req       = r;
		req_valid = 1'b1;
		waited    = 0;
		while (!req_ready && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (!req_ready) begin
			abort_run("timeout: request never accepted");
		end else begin
			exp_q.push_back(expect_rsp(r));
			cyc_q.push_back((op == NONE || misaligned(r)) ? cyc + 1 : -1);
			update_shadow(r);
			@(negedge clk);
			req_valid = 1'b0;
		end
	endtask

	task automatic drain_responses();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < TIMEOUT * 4) begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			abort_run("timeout: responses still outstanding");
		end
	endtask

	task automatic end_test(string name);
		drain_responses();
		test_cnt++;
		$display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_base);
		test_base = err_cnt;
	endtask

	// compares every write-back pulse with the oldest expectation
	initial begin
		wait_cnt = 0;
		forever begin
			@(negedge clk);
			if (exp_q.size() == 0) begin
				wait_cnt = 0;
				if (rsp_valid) begin
					abort_run("unexpected rsp_valid_o with nothing in flight");
				end
			end else if (rsp_valid) begin
				check_value("rsp_o.rd", xlen_t'(rsp.rd), xlen_t'(exp_q[0].rd));
				check_value("rsp_o.data", rsp.data, exp_q[0].data);
				check_value("rsp_o.err", xlen_t'(rsp.err), xlen_t'(exp_q[0].err));
				if (cyc_q[0] >= 0) begin
					check_value("rsp_cycle", xlen_t'(cyc), xlen_t'(cyc_q[0]));
				end
				void'(exp_q.pop_front());
				void'(cyc_q.pop_front());
				wait_cnt = 0;
			end else begin
				wait_cnt++;
				if (wait_cnt > TIMEOUT) begin
					abort_run("timeout: no rsp_valid_o for an accepted request");
				end
			end
		end
	end

	initial begin
		lsu_size_e sizes[5];
		lsu_op_e   op;
		lsu_size_e size;
		addr_t     addr;
		xlen_t     fill;
		int        cnt_before;
		void'($urandom(32'h5e8f));
		sizes     = '{BYTE, HALF, WORD, BYTE_U, HALF_U};
		rstn      = 1'b1;
		req_valid = 1'b0;
		req       = '0;
		stall_en  = 1'b0;
		cyc = 0;
		mem_req_cnt = 0;
		err_cnt = 0;
		check_cnt = 0;
		test_cnt = 0;
		test_base = 0;
		for (int i = 0; i < 1024; i++) begin
			fill      = fill_word(addr_t'(i & ~3));
			shadow[i] = fill[8*(i%4) +: 8];
		end
		repeat (4) @(negedge clk);
		rstn = 1'b0;
		@(negedge clk);

		issue(STORE, WORD, 32'h100, 32'hdead_beef, 5'd3);
		issue(LOAD, WORD, 32'h100, 32'h0, 5'd5);
		end_test("word store and load");

		for (int o = 0; o < 4; o++) begin
			issue(STORE, BYTE, addr_t'(32'h40 + o), xlen_t'(32'h7e + 16 * o), 5'd1);
			issue(LOAD, BYTE, addr_t'(32'h40 + o), 32'h0, 5'd2);
			issue(LOAD, BYTE_U, addr_t'(32'h40 + o), 32'h0, 5'd3);
		end
		issue(LOAD, WORD, 32'h40, 32'h0, 5'd4);
		for (int o = 0; o < 4; o += 2) begin
			issue(STORE, HALF, addr_t'(32'h80 + o), xlen_t'(32'h8001 + 32'h3f00 * o), 5'd6);
			issue(LOAD, HALF, addr_t'(32'h80 + o), 32'h0, 5'd7);
			issue(LOAD, HALF_U, addr_t'(32'h80 + o), 32'h0, 5'd8);
		end
		issue(LOAD, WORD, 32'h80, 32'h0, 5'd9);
		end_test("byte and half-word lanes");

		cnt_before = mem_req_cnt;
		issue(LOAD, HALF, 32'h101, 32'h0, 5'd10);
		issue(STORE, HALF_U, 32'h103, 32'h1234, 5'd11);
		for (int o = 1; o < 4; o++) begin
			issue(LOAD, WORD, addr_t'(32'h100 + o), 32'h0, 5'd12);
			issue(STORE, WORD, addr_t'(32'h100 + o), 32'hffff_ffff, 5'd13);
		end
		drain_responses();
		check_value("mem_req_count", xlen_t'(mem_req_cnt), xlen_t'(cnt_before));
		end_test("misaligned accesses");

		issue(NONE, WORD, 32'h1234_5678, 32'h0, 5'd7);
		issue(NONE, BYTE, 32'hfedc_ba98, 32'h5555_5555, 5'd31);
		end_test("non-memory result");

		issue(STORE, WORD, 32'h3c4, 32'h0bad_f00d, 5'd14);
		issue(LOAD, BYTE_U, 32'h3c5, 32'h0, 5'd15);
		drain_responses();
		check_value("mem_word", lsu_mem_model_inst.mem[8'hf1], fill_word(32'h3c4));
		end_test("error window");

		stall_en = 1'b1;
		for (int n = 0; n < 300; n++) begin
			op   = lsu_op_e'(2'($urandom % 3));
			size = sizes[int'($urandom % 5)];
			addr = addr_t'($urandom % 1024);
			if ($urandom % 5 != 0) begin
				addr = (size == WORD) ? (addr & ~addr_t'(3)) : addr;
				addr = (size == HALF || size == HALF_U) ? (addr & ~addr_t'(1)) : addr;
			end
			issue(op, size, addr, xlen_t'($urandom), 5'($urandom));
		end
		end_test("random traffic with stalls");

		err_cnt += int'(lsu_top_inst.lsu_properties_inst.fail_cnt);
		$display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_ctrl.sv
rtl/lsu_store_align.sv
rtl/lsu_load_extend.sv
rtl/lsu_top.sv
tb/lsu_mem_model.sv
tb/lsu_properties.sv
tb/lsu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= lsu_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f compile.f --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
